/* logic/dataMem_macros.svh */
`ifndef DATA_MEM_MACROS_SVH
`define DATA_MEM_MACROS_SVH

// the data RAM holds 2048 words of 32 bits behind these word address bits
`define DATA_ADDR_BITS 11

// CPU byte addresses carry the two lane bits below the word address
`define BYTE_ADDR_BITS (`DATA_ADDR_BITS + 2)

// width of the word count of one fill run
`define FILL_COUNT_BITS 8

`endif

/* logic/memBusPkg.sv */
`default_nettype none

`include "dataMem_macros.svh"

package memBusPkg;

   // RISC-V load and store flavours handled by the load/store unit
   typedef enum logic [2:0] {
      opLoadByte,
      opLoadByteU,
      opLoadHalf,
      opLoadHalfU,
      opLoadWord,
      opStoreByte,
      opStoreHalf,
      opStoreWord
   } memOp_t;

   // one access on the shared RAM bus
   typedef struct packed {
      logic [`DATA_ADDR_BITS-1:0] wordAddr;
      logic                       writeEn;
      logic [3:0]                 byteMask;   // lanes touched by a write
      logic [31:0]                writeData;  // low-aligned data that the RAM steers into lanes
   } busCmd_t;

   typedef struct packed {
      memOp_t                     op;
      logic [`BYTE_ADDR_BITS-1:0] byteAddr;
      logic [31:0]                storeData;
   } lsuReq_t;

   typedef struct packed {
      logic [`DATA_ADDR_BITS-1:0]  baseWord;
      logic [`FILL_COUNT_BITS-1:0] wordCount;
      logic [31:0]                 pattern;
   } fillReq_t;

   typedef enum logic {
      fillIdle,
      fillRun
   } fillState_t;

endpackage

`default_nettype wire

/* logic/byteLaneRam.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dataMem_macros.svh"

module byteLaneRam
   import memBusPkg::*;
   #(
      parameter int addrBits = `DATA_ADDR_BITS
   )
   (
      input  wire logic        clk,
      input  wire busCmd_t     cmd,
      output logic [31:0]      readWord
   );

   logic [addrBits-1:0] laneAddr;
   logic [1:0]          laneShift;   // lane that receives byte 0 of the write data
   logic [31:0]         steered;

   assign laneAddr = cmd.wordAddr[addrBits-1:0];

   // the lowest set bit of a legal mask tells where the low-aligned data lands
   always_comb begin
      laneShift = 2'd0;
      case (cmd.byteMask)
         4'b0001: laneShift = 2'd0;
         4'b0010: laneShift = 2'd1;
         4'b0100: laneShift = 2'd2;
         4'b1000: laneShift = 2'd3;
         4'b0011: laneShift = 2'd0;
         4'b0110: laneShift = 2'd1;
         4'b1100: laneShift = 2'd2;
         4'b1111: laneShift = 2'd0;
         default: laneShift = 2'd0;   // other masks are never issued
      endcase
   end

   assign steered = cmd.writeData << {laneShift, 3'b000};

   for (genvar lane = 0; lane < 4; lane++) begin : gLane
      logic [7:0] laneMem [2**addrBits];
      logic [7:0] readByte;

      // a lane being written keeps the byte it read last time
      always_ff @(posedge clk) begin
         if (cmd.writeEn && cmd.byteMask[lane]) begin
            laneMem[laneAddr] <= steered[8*lane +: 8];
         end else begin
            readByte <= laneMem[laneAddr];
         end
      end

      assign readWord[8*lane +: 8] = readByte;
   end

endmodule

`default_nettype wire

/* logic/busArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module busArbiter
   import memBusPkg::*;
   (
      input  wire logic    clk,
      input  wire logic    arstN,
      input  wire logic    lsuReq,
      input  wire busCmd_t lsuCmd,
      input  wire logic    fillReq,
      input  wire busCmd_t fillCmd,
      output logic         lsuGrant,
      output logic         fillGrant,
      output busCmd_t      ramCmd
   );

   logic lastFill;   // set when the fill engine had the bus last

   // a lone requester wins at once and a tie goes to whoever waited last time
   always_comb begin
      lsuGrant  = 1'b0;
      fillGrant = 1'b0;
      if (lsuReq && fillReq) begin
         if (lastFill) begin
            lsuGrant = 1'b1;
         end else begin
            fillGrant = 1'b1;
         end
      end else begin
         lsuGrant  = lsuReq;
         fillGrant = fillReq;
      end
   end

   // out of reset the pointer says fill went last, so the LSU wins the first tie
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         lastFill <= 1'b1;
      end else if (lsuGrant) begin
         lastFill <= 1'b0;
      end else if (fillGrant) begin
         lastFill <= 1'b1;
      end
   end

   always_comb begin
      if (lsuGrant) begin
         ramCmd = lsuCmd;
      end else if (fillGrant) begin
         ramCmd = fillCmd;
      end else begin
         ramCmd = '0;   // idle cycle is a read of word 0 with nothing written
      end
   end

endmodule

`default_nettype wire

/* logic/loadExtract.sv */
`timescale 1ns/100ps
`default_nettype none

module loadExtract
   import memBusPkg::*;
   (
      input  wire memOp_t      op,
      input  wire logic [1:0]  byteOffset,
      input  wire logic [31:0] readWord,
      output logic [31:0]      loadData
   );

   logic [31:0] shifted;
   logic [7:0]  selByte;
   logic [15:0] selHalf;

   // bring the addressed byte or halfword down to bit 0
   assign shifted = readWord >> {byteOffset, 3'b000};
   assign selByte = shifted[7:0];
   assign selHalf = shifted[15:0];

   always_comb begin
      case (op)
         opLoadByte: begin
            loadData = {{24{selByte[7]}}, selByte};
         end
         opLoadByteU: begin
            loadData = {24'd0, selByte};
         end
         opLoadHalf: begin
            loadData = {{16{selHalf[15]}}, selHalf};
         end
         opLoadHalfU: begin
            loadData = {16'd0, selHalf};
         end
         default: begin
            loadData = readWord;   // word loads, and stores where it is not used
         end
      endcase
   end

endmodule

`default_nettype wire

/* logic/loadStoreUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dataMem_macros.svh"

module loadStoreUnit
   import memBusPkg::*;
   (
      input  wire logic        clk,
      input  wire logic        arstN,
      input  wire logic        start,
      input  wire lsuReq_t     req,
      input  wire logic        grant,
      input  wire logic [31:0] readWord,
      output logic             busReq,
      output busCmd_t          cmd,
      output logic             busy,
      output logic             done,
      output logic [31:0]      loadData
   );

   lsuReq_t     reqReg;
   busCmd_t     cmdReg;
   logic        issuePending;   // the command is built on the edge after the capture
   logic        readPending;    // the RAM has acted and its result is on readWord
   logic        isStore;
   logic [3:0]  laneMask;
   logic [31:0] extracted;

   always_comb begin
      isStore  = 1'b0;
      laneMask = 4'b1111;
      case (reqReg.op)
         opLoadByte, opLoadByteU: laneMask = 4'b0001 << reqReg.byteAddr[1:0];
         opLoadHalf, opLoadHalfU: laneMask = 4'b0011 << reqReg.byteAddr[1:0];
         opStoreByte: begin
            isStore  = 1'b1;
            laneMask = 4'b0001 << reqReg.byteAddr[1:0];
         end
         opStoreHalf: begin
            isStore  = 1'b1;
            laneMask = 4'b0011 << reqReg.byteAddr[1:0];
         end
         opStoreWord: isStore = 1'b1;
         default: laneMask = 4'b1111;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         busy         <= 1'b0;
         issuePending <= 1'b0;
         busReq       <= 1'b0;
         readPending  <= 1'b0;
         done         <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start && !busy) begin   // a start while busy is dropped
            busy         <= 1'b1;
            issuePending <= 1'b1;
         end
         if (issuePending) begin
            issuePending <= 1'b0;
            busReq       <= 1'b1;
         end
         if (busReq && grant) begin
            busReq      <= 1'b0;
            readPending <= 1'b1;
         end
         if (readPending) begin
            readPending <= 1'b0;
            done        <= 1'b1;
            busy        <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start && !busy) reqReg <= req;
      if (issuePending) begin
         cmdReg <= '{wordAddr:  reqReg.byteAddr[`BYTE_ADDR_BITS-1:2],
                     writeEn:   isStore,
                     byteMask:  laneMask,
                     writeData: reqReg.storeData};
      end
      if (readPending) loadData <= extracted;
   end

   assign cmd = cmdReg;   // held steady until the grant arrives

   loadExtract uExtract (
      .op         (reqReg.op),
      .byteOffset (reqReg.byteAddr[1:0]),
      .readWord   (readWord),
      .loadData   (extracted)
   );

endmodule

`default_nettype wire

/* logic/memFillEngine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dataMem_macros.svh"

module memFillEngine
   import memBusPkg::*;
   (
      input  wire logic     clk,
      input  wire logic     arstN,
      input  wire logic     start,
      input  wire fillReq_t req,
      input  wire logic     grant,
      output logic          busReq,
      output busCmd_t       cmd,
      output logic          busy,
      output logic          done
   );

   localparam int addrBits  = `DATA_ADDR_BITS;
   localparam int countBits = `FILL_COUNT_BITS;

   fillState_t           state;
   fillReq_t             reqReg;
   logic [countBits-1:0] index;    // word of the run currently offered
   logic                 lastWord;

   assign busy     = (state == fillRun);
   assign busReq   = busy && (index != reqReg.wordCount);   // low for an empty run
   assign lastWord = (index == reqReg.wordCount - countBits'(1));

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= fillIdle;
         index <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            fillIdle: begin
               if (start) begin
                  state <= fillRun;
                  index <= '0;
               end
            end
            fillRun: begin
               if (!busReq) begin        // zero count finishes one cycle after start
                  state <= fillIdle;
                  done  <= 1'b1;
               end else if (grant) begin
                  if (lastWord) begin
                     state <= fillIdle;
                     done  <= 1'b1;
                  end else begin
                     index <= index + countBits'(1);
                  end
               end
            end
            default: state <= fillIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start && state == fillIdle) reqReg <= req;
   end

   assign cmd.wordAddr  = reqReg.baseWord + addrBits'(index);
   assign cmd.writeEn   = 1'b1;
   assign cmd.byteMask  = 4'b1111;
   assign cmd.writeData = reqReg.pattern + 32'(index);

endmodule

`default_nettype wire

/* logic/dataMemSubsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module dataMemSubsystem
   import memBusPkg::*;
   (
      input  wire logic     clk,
      input  wire logic     arstN,
      input  wire logic     lsuStart,
      input  wire lsuReq_t  lsuRequest,
      output logic          lsuBusy,
      output logic          lsuDone,
      output logic [31:0]   lsuLoadData,
      input  wire logic     fillStart,
      input  wire fillReq_t fillRequest,
      output logic          fillBusy,
      output logic          fillDone
   );

   logic        lsuBusReq;
   logic        fillBusReq;
   logic        lsuGrant;
   logic        fillGrant;
   busCmd_t     lsuCmd;
   busCmd_t     fillCmd;
   busCmd_t     ramCmd;
   logic [31:0] readWord;

   loadStoreUnit uLsu (
      .clk      (clk),
      .arstN    (arstN),
      .start    (lsuStart),
      .req      (lsuRequest),
      .grant    (lsuGrant),
      .readWord (readWord),
      .busReq   (lsuBusReq),
      .cmd      (lsuCmd),
      .busy     (lsuBusy),
      .done     (lsuDone),
      .loadData (lsuLoadData)
   );

   memFillEngine uFill (
      .clk    (clk),
      .arstN  (arstN),
      .start  (fillStart),
      .req    (fillRequest),
      .grant  (fillGrant),
      .busReq (fillBusReq),
      .cmd    (fillCmd),
      .busy   (fillBusy),
      .done   (fillDone)
   );

   busArbiter uArbiter (
      .clk       (clk),
      .arstN     (arstN),
      .lsuReq    (lsuBusReq),
      .lsuCmd    (lsuCmd),
      .fillReq   (fillBusReq),
      .fillCmd   (fillCmd),
      .lsuGrant  (lsuGrant),
      .fillGrant (fillGrant),
      .ramCmd    (ramCmd)
   );

   byteLaneRam uRam (
      .clk      (clk),
      .cmd      (ramCmd),
      .readWord (readWord)
   );

endmodule

`default_nettype wire

/* testbench/dataMemTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dataMem_macros.svh"

module dataMemTb
   import memBusPkg::*;
   ();

   localparam int wordsTotal   = 2**`DATA_ADDR_BITS;
   localparam int resetCycles  = 4;
   localparam int accessLimit  = 40;    // one access even when stuck behind a long fill
   localparam int lsuOpsMax    = 320;   // worst-case access count over all tests
   localparam int lsuOpCycles  = 8;
   localparam int fillWordsMax = 140;
   localparam int cycleLimit   = 2 * (resetCycles + lsuOpsMax * lsuOpCycles
                                      + 2 * fillWordsMax + 40);

   logic        clk;
   logic        arstN;
   logic        lsuStart;
   lsuReq_t     lsuRequest;
   logic        lsuBusy;
   logic        lsuDone;
   logic [31:0] lsuLoadData;
   logic        fillStart;
   fillReq_t    fillRequest;
   logic        fillBusy;
   logic        fillDone;

   logic [7:0]  model [wordsTotal*4];   // byte-addressed reference memory
   fillReq_t    activeFill;
   int          fillDones;
   int          fillMark;
   int          errors;
   int          checks;
   int          testMark;
   int          testsRun;
   int          cycles;
   int          seed = 26;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   dataMemSubsystem u_dut (
      .clk         (clk),
      .arstN       (arstN),
      .lsuStart    (lsuStart),
      .lsuRequest  (lsuRequest),
      .lsuBusy     (lsuBusy),
      .lsuDone     (lsuDone),
      .lsuLoadData (lsuLoadData),
      .fillStart   (fillStart),
      .fillRequest (fillRequest),
      .fillBusy    (fillBusy),
      .fillDone    (fillDone)
   );

   // done closes a busy stretch, so busy has just fallen when done shows
   assert property (@(posedge clk) disable iff (!arstN) lsuDone |-> !lsuBusy && $past(lsuBusy))
      else begin
         errors++;
         $display("lsuDone pulsed without the load/store busy period ending with it");
      end
   assert property (@(posedge clk) disable iff (!arstN) fillDone |-> !fillBusy && $past(fillBusy))
      else begin
         errors++;
         $display("fillDone pulsed without the fill busy period ending with it");
      end
   assert property (@(posedge clk) disable iff (!arstN) $rose(lsuBusy) |-> $past(lsuStart))
      else begin
         errors++;
         $display("lsuBusy rose without a start pulse");
      end

   function automatic logic [31:0] nextRandom();
      return $random(seed);
   endfunction

   function automatic void storeModel(memOp_t op, int addr, logic [31:0] data);
      int n;
      case (op)
         opStoreByte: n = 1;
         opStoreHalf: n = 2;
         default:     n = 4;
      endcase
      for (int k = 0; k < n; k++) model[addr+k] = data[8*k +: 8];
   endfunction

   // RISC-V extension rules applied to the model bytes
   function automatic logic [31:0] expectLoad(memOp_t op, int addr);
      logic [7:0]  b;
      logic [15:0] h;
      b = model[addr];
      h = {model[addr+1], model[addr]};
      case (op)
         opLoadByte:  return {{24{b[7]}}, b};
         opLoadByteU: return {24'd0, b};
         opLoadHalf:  return {{16{h[15]}}, h};
         opLoadHalfU: return {16'd0, h};
         default:     return {model[addr+3], model[addr+2], model[addr+1], model[addr]};
      endcase
   endfunction

   function automatic void applyFill(fillReq_t f);
      int          w;
      logic [31:0] v;
      for (int i = 0; i < int'(f.wordCount); i++) begin
         w = (int'(f.baseWord) + i) % wordsTotal;
         v = f.pattern + 32'(i);
         for (int k = 0; k < 4; k++) model[4*w+k] = v[8*k +: 8];
      end
   endfunction

   // the whole run lands in the model once the engine reports done
   always @(posedge clk) begin
      if (arstN && fillDone) begin
         applyFill(activeFill);
         fillDones++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("timeout, the run was stopped after %0d cycles", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic lsuAccess(input memOp_t op, input int addr, input logic [31:0] data,
                            output int latency);
      logic [31:0] expected;
      logic [31:0] addrWide;
      addrWide = 32'(addr);
      @(negedge clk);
      lsuStart             = 1'b1;
      lsuRequest.op        = op;
      lsuRequest.byteAddr  = addrWide[`BYTE_ADDR_BITS-1:0];
      lsuRequest.storeData = data;
      @(negedge clk);
      lsuStart = 1'b0;
      latency  = 0;
      while (!lsuDone && latency < accessLimit) begin
         @(negedge clk);
         latency++;
      end
      checks++;
      if (!lsuDone) begin
         errors++;
         $display("load/store unit never finished %s at byte address %h", op.name(), addr);
      end else if (op inside {opStoreByte, opStoreHalf, opStoreWord}) begin
         storeModel(op, addr, data);
      end else begin
         expected = expectLoad(op, addr);
         assert (lsuLoadData === expected) else begin
            errors++;
            $display("MISMATCH lsuLoadData %s at %h: got %h expected %h",
                     op.name(), addr, lsuLoadData, expected);
         end
      end
   endtask

   task automatic checkWords(input int first, input int last);
      int lat;
      for (int w = first; w <= last; w++) lsuAccess(opLoadWord, 4*w, 32'd0, lat);
   endtask

   task automatic startFill(input int base, input int count, input logic [31:0] pattern);
      logic [31:0] b;
      logic [31:0] c;
      b = 32'(base);
      c = 32'(count);
      @(negedge clk);
      fillRequest.baseWord  = b[`DATA_ADDR_BITS-1:0];
      fillRequest.wordCount = c[`FILL_COUNT_BITS-1:0];
      fillRequest.pattern   = pattern;
      activeFill = fillRequest;
      fillMark   = fillDones;
      fillStart  = 1'b1;
      @(negedge clk);
      fillStart = 1'b0;
   endtask

   task automatic waitFill();
      int waited;
      waited = 0;
      while (fillDones == fillMark && waited < 2*wordsTotal) begin
         @(negedge clk);
         waited++;
      end
      checks++;
      if (fillDones == fillMark) begin
         errors++;
         $display("fill engine never signalled done");
      end
   endtask

   task automatic endTest(input string name);
      testsRun++;
      $display("test %0d %s: %0d errors", testsRun, name, errors - testMark);
      testMark = errors;
   endtask

   initial begin
      int          lat;
      int          addr;
      int          base;
      int          count;
      logic [31:0] r;
      arstN       = 1'b0;
      lsuStart    = 1'b0;
      lsuRequest  = '0;
      fillStart   = 1'b0;
      fillRequest = '0;
      activeFill  = '0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;

      checks++;
      assert (!lsuBusy && !lsuDone && !fillBusy && !fillDone) else begin
         errors++;
         $display("busy or done flags are not low after reset");
      end
      startFill(0, 64, nextRandom());   // gives the words used below known contents
      waitFill();
      lsuAccess(opStoreWord, 12, 32'hA5A5_0F0F, lat);
      lsuAccess(opLoadWord, 12, 32'd0, lat);
      checks++;
      assert (lat == 3) else begin
         errors++;
         $display("MISMATCH lsuDone latency: got %h expected %h", lat, 3);
      end
      endTest("reset state and load latency");

      for (int n = 0; n < 24; n++) begin
         r = nextRandom();
         lsuAccess(opStoreWord, 4*int'(r[5:0]), nextRandom(), lat);
      end
      for (int w = 0; w < 64; w++) lsuAccess(opLoadWord, 4*w, 32'd0, lat);
      endTest("word stores and loads");

      for (int n = 0; n < 6; n++) begin
         r    = nextRandom();
         addr = 4*int'(r[4:0]);
         lsuAccess(opStoreWord, addr, nextRandom(), lat);
         for (int off = 0; off < 4; off++) begin
            lsuAccess(opStoreByte, addr + off, nextRandom(), lat);
            lsuAccess(opLoadWord, addr, 32'd0, lat);
         end
         for (int off = 0; off < 3; off++) begin
            lsuAccess(opStoreHalf, addr + off, nextRandom(), lat);
            lsuAccess(opLoadWord, addr, 32'd0, lat);
         end
      end
      endTest("byte and halfword merges");

      lsuAccess(opStoreWord, 16, 32'h80FF_7F01, lat);
      lsuAccess(opStoreWord, 20, 32'h7F00_8081, lat);
      for (int a = 16; a <= 20; a += 4) begin
         for (int off = 0; off < 4; off++) begin
            lsuAccess(opLoadByte, a + off, 32'd0, lat);
            lsuAccess(opLoadByteU, a + off, 32'd0, lat);
         end
         for (int off = 0; off < 3; off++) begin
            lsuAccess(opLoadHalf, a + off, 32'd0, lat);
            lsuAccess(opLoadHalfU, a + off, 32'd0, lat);
         end
      end
      endTest("signed and unsigned loads");

      for (int n = 0; n < 3; n++) begin
         r     = nextRandom();
         base  = 36 + int'(r[2:0]);
         count = 1 + int'(r[7:4]);
         startFill(base, count, nextRandom());
         waitFill();
         checkWords(base - 1, base + count);   // the run plus one neighbour each side
      end
      startFill(10, 0, nextRandom());
      waitFill();
      checkWords(9, 11);
      endTest("fill runs");

      startFill(40, 20, nextRandom());
      checks++;
      assert (fillBusy) else begin
         errors++;
         $display("fill engine was not busy when the overlapping accesses began");
      end
      for (int n = 0; n < 6; n++) begin
         r    = nextRandom();
         addr = 4*int'(r[4:0]);
         lsuAccess(opStoreWord, addr, nextRandom(), lat);
         lsuAccess(opLoadByte, addr + int'(r[9:8]), 32'd0, lat);
      end
      waitFill();
      checkWords(39, 60);
      endTest("accesses during a fill");

      $display("tests run %0d, checks %0d, errors %0d", testsRun, checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/memBusPkg.sv
logic/byteLaneRam.sv
logic/busArbiter.sv
logic/loadExtract.sv
logic/loadStoreUnit.sv
logic/memFillEngine.sv
logic/dataMemSubsystem.sv
testbench/dataMemTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = dataMemTb
FILELIST  = compile.f
OBJDIR    = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the simulation passes only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
